//--- stdPkg.sv
package stdPkg;

    // Physical register tag, top bit set marks an immediate
    typedef logic [6:0] Tag_t;

    // Store sequence number, wraps and is compared by signed difference
    typedef logic [5:0] SqN_t;

    // Byte offset of a store within a word
    typedef logic [1:0] StOff_t;

    typedef logic [3:0] Opcode_t;

    localparam Opcode_t OP_SB = 4'd1;
    localparam Opcode_t OP_SH = 4'd2;
    localparam Opcode_t OP_SW = 4'd3;

    // Cache maintenance ops, kept contiguous for the immediate tag encoding
    localparam Opcode_t OP_CBO_CLEAN = 4'd8;
    localparam Opcode_t OP_CBO_INVAL = 4'd9;
    localparam Opcode_t OP_CBO_FLUSH = 4'd10;

    // Base of the immediate tag range
    localparam Tag_t TAG_ZERO = 7'h40;

    localparam int QUEUE_SIZE = 8;

    // Insert index counts 0 to QUEUE_SIZE inclusive
    localparam int QIDX_W = 4;

endpackage

//--- storeUopDecode.sv
`timescale 1ns/1ns

module storeUopDecode (
    input  logic             uopValid,
    input  stdPkg::Opcode_t  uopOp,
    input  stdPkg::Tag_t     uopTag,
    input  logic             uopAvail,
    input  stdPkg::SqN_t     uopSqN,

    input  logic             resValid,
    input  stdPkg::Tag_t     resTag,

    output logic             entValid,
    output stdPkg::Tag_t     entTag,
    output logic             entAvail,
    output logic             entOffsAvail,
    output stdPkg::SqN_t     entSqN
);

    logic isSw;
    logic isSh;
    logic isSb;
    logic isCbo;
    logic resHit;

    assign isSw = (uopOp == stdPkg::OP_SW);
    assign isSh = (uopOp == stdPkg::OP_SH);
    assign isSb = (uopOp == stdPkg::OP_SB);
    assign isCbo = (uopOp >= stdPkg::OP_CBO_CLEAN) && (uopOp <= stdPkg::OP_CBO_FLUSH);

    assign entValid = uopValid && (isSw || isSh || isSb || isCbo);

    // Immediate tags never match the result bus
    assign resHit = resValid && !resTag[$bits(stdPkg::Tag_t)-1] && (resTag == uopTag);

    always_comb begin
        entTag = uopTag;
        entAvail = uopAvail || resHit;
        // CBO kind is passed to the store queue as an immediate tag
        if (isCbo) begin
            entTag = stdPkg::TAG_ZERO + stdPkg::Tag_t'(uopOp - stdPkg::OP_CBO_CLEAN);
            entAvail = 1'b1;
        end
    end

    // Sub-word stores need the low address bits from the AGU first
    assign entOffsAvail = !(isSb || isSh);

    assign entSqN = uopSqN;

endmodule

//--- storeDataQueue.sv
`timescale 1ns/1ns

module storeDataQueue (
    input  logic             clk,
    input  logic             rst,

    input  logic             entValid,
    input  stdPkg::Tag_t     entTag,
    input  logic             entAvail,
    input  logic             entOffsAvail,
    input  stdPkg::SqN_t     entSqN,
    output logic             uopStall,

    input  logic             resValid,
    input  stdPkg::Tag_t     resTag,

    input  logic             aguValid,
    input  stdPkg::Opcode_t  aguOp,
    input  stdPkg::SqN_t     aguSqN,
    input  stdPkg::StOff_t   aguSrcA,
    input  stdPkg::StOff_t   aguSrcB,

    input  logic             brTaken,
    input  logic             brFlush,
    input  stdPkg::SqN_t     brSqN,

    input  stdPkg::SqN_t     maxStoreSqN,

    input  logic             issueAccept,
    output logic             pickValid,
    output stdPkg::Tag_t     pickTag,
    output stdPkg::SqN_t     pickSqN,
    output stdPkg::StOff_t   pickOffs,

    output logic             comLimitValid,
    output stdPkg::SqN_t     comLimitSqN
);

    stdPkg::Tag_t   qTag       [stdPkg::QUEUE_SIZE];
    stdPkg::SqN_t   qSqN       [stdPkg::QUEUE_SIZE];
    stdPkg::StOff_t qOffs      [stdPkg::QUEUE_SIZE];
    logic           qAvail     [stdPkg::QUEUE_SIZE];
    logic           qOffsAvail [stdPkg::QUEUE_SIZE];

    logic [stdPkg::QIDX_W-1:0] insertIndex;
    logic [stdPkg::QIDX_W-1:0] baseIndex;
    logic [stdPkg::QIDX_W-1:0] nextIndex;
    logic [stdPkg::QIDX_W-1:0] rollbackIndex;
    logic [stdPkg::QIDX_W-2:0] pickIdx;

    logic           availNext     [stdPkg::QUEUE_SIZE];
    logic           offsAvailNext [stdPkg::QUEUE_SIZE];
    stdPkg::StOff_t offsNext      [stdPkg::QUEUE_SIZE];
    logic           ready         [stdPkg::QUEUE_SIZE];

    logic           resLive;
    logic           aguSubWord;
    stdPkg::StOff_t aguOffs;
    logic           anyReady;
    logic           doEnq;
    logic           doDeq;

    assign comLimitValid = (insertIndex != '0);
    assign comLimitSqN = qSqN[0];

    assign uopStall = entValid && ((insertIndex == stdPkg::QIDX_W'(stdPkg::QUEUE_SIZE)) || brTaken);
    assign doEnq = entValid && !uopStall;

    assign resLive = resValid && !resTag[$bits(stdPkg::Tag_t)-1];
    assign aguSubWord = aguValid && ((aguOp == stdPkg::OP_SB) || (aguOp == stdPkg::OP_SH));
    assign aguOffs = aguSrcA + aguSrcB;

    // Wakeup, offset snoop and readiness per entry
    always_comb begin
        for (int i = 0; i < stdPkg::QUEUE_SIZE; i++) begin
            availNext[i] = qAvail[i] || (resLive && (qTag[i] == resTag));
            offsAvailNext[i] = qOffsAvail[i];
            offsNext[i] = qOffs[i];
            if (aguSubWord && (qSqN[i] == aguSqN)) begin
                offsAvailNext[i] = 1'b1;
                offsNext[i] = aguOffs;
            end
            // Snooped offsets only count from the next cycle on
            ready[i] = (i < insertIndex) && availNext[i] && qOffsAvail[i] &&
                ($signed(stdPkg::SqN_t'(qSqN[i] - maxStoreSqN)) <= 0);
        end
    end

    // Oldest ready entry
    always_comb begin
        anyReady = 1'b0;
        pickIdx = '0;
        for (int i = stdPkg::QUEUE_SIZE - 1; i >= 0; i--) begin
            if (ready[i]) begin
                anyReady = 1'b1;
                pickIdx = i[stdPkg::QIDX_W-2:0];
            end
        end
    end

    assign pickValid = anyReady && !brTaken;
    assign pickTag = qTag[pickIdx];
    assign pickSqN = qSqN[pickIdx];
    assign pickOffs = qOffs[pickIdx];

    assign doDeq = pickValid && issueAccept;

    assign baseIndex = insertIndex - stdPkg::QIDX_W'(doDeq);
    assign nextIndex = baseIndex + stdPkg::QIDX_W'(doEnq);

    // Keep everything up to the last entry not younger than the branch
    always_comb begin
        rollbackIndex = '0;
        for (int i = 0; i < stdPkg::QUEUE_SIZE; i++) begin
            if ((i < insertIndex) && !brFlush &&
                ($signed(stdPkg::SqN_t'(qSqN[i] - brSqN)) <= 0)) begin
                rollbackIndex = stdPkg::QIDX_W'(i + 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < stdPkg::QUEUE_SIZE; i++) begin
            qAvail[i] <= availNext[i];
            qOffsAvail[i] <= offsAvailNext[i];
            qOffs[i] <= offsNext[i];
        end

        // Compact younger entries over the picked one
        if (doDeq) begin
            for (int i = 0; i < stdPkg::QUEUE_SIZE - 1; i++) begin
                if (i >= pickIdx) begin
                    qTag[i] <= qTag[i+1];
                    qSqN[i] <= qSqN[i+1];
                    qAvail[i] <= availNext[i+1];
                    qOffsAvail[i] <= offsAvailNext[i+1];
                    qOffs[i] <= offsNext[i+1];
                end
            end
        end

        if (doEnq) begin
            qTag[baseIndex[stdPkg::QIDX_W-2:0]] <= entTag;
            qSqN[baseIndex[stdPkg::QIDX_W-2:0]] <= entSqN;
            qAvail[baseIndex[stdPkg::QIDX_W-2:0]] <= entAvail;
            qOffsAvail[baseIndex[stdPkg::QIDX_W-2:0]] <= entOffsAvail;
            qOffs[baseIndex[stdPkg::QIDX_W-2:0]] <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            insertIndex <= '0;
        end else if (brTaken) begin
            insertIndex <= rollbackIndex;
        end else begin
            insertIndex <= nextIndex;
        end
    end

    aIndexBound: assert property (@(posedge clk) disable iff (rst)
        insertIndex <= stdPkg::QIDX_W'(stdPkg::QUEUE_SIZE));

    // A branch cycle can only shrink the queue
    aNoEnqOnBranch: assert property (@(posedge clk) disable iff (rst)
        brTaken |=> insertIndex <= $past(insertIndex));

endmodule

//--- storeDataIssue.sv
`timescale 1ns/1ns

module storeDataIssue (
    input  logic             clk,
    input  logic             rst,

    input  logic             pickValid,
    input  stdPkg::Tag_t     pickTag,
    input  stdPkg::SqN_t     pickSqN,
    input  stdPkg::StOff_t   pickOffs,
    output logic             issueAccept,

    input  logic             brTaken,
    input  logic             brFlush,
    input  stdPkg::SqN_t     brSqN,

    output logic             outValid,
    output stdPkg::Tag_t     outTag,
    output stdPkg::SqN_t     outSqN,
    output stdPkg::StOff_t   outOffs,
    input  logic             outReady
);

    logic kill;

    assign issueAccept = !outValid || outReady;

    // Consumed, younger than the branch, or flushed
    assign kill = brTaken &&
        (outReady || brFlush || ($signed(stdPkg::SqN_t'(outSqN - brSqN)) > 0));

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (brTaken) begin
            if (kill) begin
                outValid <= 1'b0;
            end
        end else if (issueAccept) begin
            outValid <= pickValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!brTaken && issueAccept && pickValid) begin
            outTag <= pickTag;
            outSqN <= pickSqN;
            outOffs <= pickOffs;
        end
    end

    aHoldUnderStall: assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady && !kill) |=>
            (outValid && $stable(outTag) && $stable(outSqN) && $stable(outOffs)));

endmodule

//--- storeDataTop.sv
`timescale 1ns/1ns

module storeDataTop (
    input  logic             clk,
    input  logic             rst,

    input  logic             uopValid,
    input  stdPkg::Opcode_t  uopOp,
    input  stdPkg::Tag_t     uopTag,
    input  logic             uopAvail,
    input  stdPkg::SqN_t     uopSqN,
    output logic             uopStall,

    input  logic             resValid,
    input  stdPkg::Tag_t     resTag,

    input  logic             aguValid,
    input  stdPkg::Opcode_t  aguOp,
    input  stdPkg::SqN_t     aguSqN,
    input  stdPkg::StOff_t   aguSrcA,
    input  stdPkg::StOff_t   aguSrcB,

    input  logic             brTaken,
    input  logic             brFlush,
    input  stdPkg::SqN_t     brSqN,

    input  stdPkg::SqN_t     maxStoreSqN,

    output logic             comLimitValid,
    output stdPkg::SqN_t     comLimitSqN,

    output logic             outValid,
    output stdPkg::Tag_t     outTag,
    output stdPkg::SqN_t     outSqN,
    output stdPkg::StOff_t   outOffs,
    input  logic             outReady
);

    logic           entValid;
    stdPkg::Tag_t   entTag;
    logic           entAvail;
    logic           entOffsAvail;
    stdPkg::SqN_t   entSqN;

    logic           issueAccept;
    logic           pickValid;
    stdPkg::Tag_t   pickTag;
    stdPkg::SqN_t   pickSqN;
    stdPkg::StOff_t pickOffs;

    storeUopDecode u_storeUopDecode (
        .uopValid     (uopValid),
        .uopOp        (uopOp),
        .uopTag       (uopTag),
        .uopAvail     (uopAvail),
        .uopSqN       (uopSqN),
        .resValid     (resValid),
        .resTag       (resTag),
        .entValid     (entValid),
        .entTag       (entTag),
        .entAvail     (entAvail),
        .entOffsAvail (entOffsAvail),
        .entSqN       (entSqN)
    );

    storeDataQueue u_storeDataQueue (
        .clk           (clk),
        .rst           (rst),
        .entValid      (entValid),
        .entTag        (entTag),
        .entAvail      (entAvail),
        .entOffsAvail  (entOffsAvail),
        .entSqN        (entSqN),
        .uopStall      (uopStall),
        .resValid      (resValid),
        .resTag        (resTag),
        .aguValid      (aguValid),
        .aguOp         (aguOp),
        .aguSqN        (aguSqN),
        .aguSrcA       (aguSrcA),
        .aguSrcB       (aguSrcB),
        .brTaken       (brTaken),
        .brFlush       (brFlush),
        .brSqN         (brSqN),
        .maxStoreSqN   (maxStoreSqN),
        .issueAccept   (issueAccept),
        .pickValid     (pickValid),
        .pickTag       (pickTag),
        .pickSqN       (pickSqN),
        .pickOffs      (pickOffs),
        .comLimitValid (comLimitValid),
        .comLimitSqN   (comLimitSqN)
    );

    storeDataIssue u_storeDataIssue (
        .clk         (clk),
        .rst         (rst),
        .pickValid   (pickValid),
        .pickTag     (pickTag),
        .pickSqN     (pickSqN),
        .pickOffs    (pickOffs),
        .issueAccept (issueAccept),
        .brTaken     (brTaken),
        .brFlush     (brFlush),
        .brSqN       (brSqN),
        .outValid    (outValid),
        .outTag      (outTag),
        .outSqN      (outSqN),
        .outOffs     (outOffs),
        .outReady    (outReady)
    );

endmodule

//--- tbStoreData.sv
`timescale 1ns/1ns

module tbStoreData;

    logic clk;
    logic rst;
    logic uopValid;
    stdPkg::Opcode_t uopOp;
    stdPkg::Tag_t uopTag;
    logic uopAvail;
    stdPkg::SqN_t uopSqN;
    logic uopStall;
    logic resValid;
    stdPkg::Tag_t resTag;
    logic aguValid;
    stdPkg::Opcode_t aguOp;
    stdPkg::SqN_t aguSqN;
    stdPkg::StOff_t aguSrcA;
    stdPkg::StOff_t aguSrcB;
    logic brTaken;
    logic brFlush;
    stdPkg::SqN_t brSqN;
    stdPkg::SqN_t maxStoreSqN;
    logic comLimitValid;
    stdPkg::SqN_t comLimitSqN;
    logic outValid;
    stdPkg::Tag_t outTag;
    stdPkg::SqN_t outSqN;
    stdPkg::StOff_t outOffs;
    logic outReady;

    stdPkg::SqN_t sq;
    int cycles;
    // Consumed outputs as {tag, sqn, offs}
    logic [14:0] obsQ[$];

    storeDataTop u_storeDataTop (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Limit well above the few hundred cycles the tests take
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 2000) begin
            abortRun("timeout: run exceeded 2000 clock cycles");
        end
    end

    always @(posedge clk) begin
        if (!rst && outValid && outReady) begin
            obsQ.push_back({outTag, outSqN, outOffs});
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopping simulation");
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic stdPkg::SqN_t nextSqN();
        nextSqN = sq;
        sq = sq + 6'd1;
    endfunction

    function automatic stdPkg::Tag_t randTag();
        randTag = {1'b0, 6'($urandom)};
    endfunction

    // Window stays within half the sequence space of every queued entry
    task automatic openWindow();
        maxStoreSqN = sq + 6'd16;
    endtask

    // Every sequence number handed out from now on lies past the window
    task automatic closeWindow();
        maxStoreSqN = sq - 6'd1;
    endtask

    task automatic enq(input stdPkg::Opcode_t op, input stdPkg::Tag_t tag, input logic avail,
                       input stdPkg::SqN_t sqn);
        uopValid = 1'b1;
        uopOp = op;
        uopTag = tag;
        uopAvail = avail;
        uopSqN = sqn;
        #1;
        check("uopStall on enqueue", uopStall, 0);
        tick();
        uopValid = 1'b0;
    endtask

    task automatic expectIssue(input stdPkg::Tag_t tag, input stdPkg::SqN_t sqn,
                               input stdPkg::StOff_t offs);
        int n;
        logic [14:0] got;
        n = 0;
        while (obsQ.size() == 0) begin
            tick();
            n++;
            if (n > 20) begin
                abortRun($sformatf("no store issued within 20 cycles, expected sqn %0h", sqn));
            end
        end
        got = obsQ.pop_front();
        check("outTag", got[14:8], tag);
        check("outSqN", got[7:2], sqn);
        check("outOffs", got[1:0], offs);
    endtask

    task automatic expectNone(input int n);
        repeat (n) tick();
        check("issued store count", obsQ.size(), 0);
    endtask

    task automatic waitOutValid();
        int n;
        n = 0;
        while (!outValid) begin
            tick();
            n++;
            if (n > 20) begin
                abortRun("outValid did not rise within 20 cycles");
            end
        end
    endtask

    task automatic testResetLimit();
        stdPkg::Tag_t t[3];
        stdPkg::SqN_t s[3];
        check("outValid after reset", outValid, 0);
        check("comLimitValid after reset", comLimitValid, 0);
        check("uopStall after reset", uopStall, 0);
        closeWindow();
        for (int i = 0; i < 3; i++) begin
            t[i] = randTag();
            s[i] = nextSqN();
            enq(stdPkg::OP_SW, t[i], 1'b1, s[i]);
        end
        check("comLimitValid", comLimitValid, 1);
        check("comLimitSqN", comLimitSqN, s[0]);
        expectNone(3);
        openWindow();
        for (int i = 0; i < 3; i++) expectIssue(t[i], s[i], 2'd0);
        check("comLimitValid when drained", comLimitValid, 0);
    endtask

    task automatic testInOrder();
        stdPkg::Tag_t t[4];
        stdPkg::SqN_t s[4];
        openWindow();
        for (int i = 0; i < 4; i++) begin
            t[i] = randTag();
            s[i] = nextSqN();
            enq(stdPkg::OP_SW, t[i], 1'b1, s[i]);
        end
        for (int i = 0; i < 4; i++) expectIssue(t[i], s[i], 2'd0);
    endtask

    task automatic testWakeup();
        stdPkg::Tag_t tA;
        stdPkg::Tag_t tB;
        stdPkg::Tag_t tI;
        stdPkg::SqN_t sA;
        stdPkg::SqN_t sB;
        stdPkg::SqN_t sI;
        openWindow();
        tA = randTag();
        tB = tA ^ 7'h01;
        tI = {1'b1, tA[5:0]};
        sA = nextSqN();
        sB = nextSqN();
        sI = nextSqN();
        enq(stdPkg::OP_SW, tA, 1'b0, sA);
        enq(stdPkg::OP_SW, tB, 1'b1, sB);
        expectIssue(tB, sB, 2'd0);
        // Entry waiting on an immediate tag, the broadcast of that exact tag must not wake it
        enq(stdPkg::OP_SW, tI, 1'b0, sI);
        resValid = 1'b1;
        resTag = tI;
        tick();
        resValid = 1'b0;
        expectNone(4);
        resValid = 1'b1;
        resTag = tA;
        tick();
        resValid = 1'b0;
        expectIssue(tA, sA, 2'd0);
        // Drop the entry that can never wake
        brTaken = 1'b1;
        brSqN = sB;
        tick();
        brTaken = 1'b0;
        check("comLimitValid after dropping immediate entry", comLimitValid, 0);
    endtask

    task automatic testSubWord(input stdPkg::Opcode_t op);
        stdPkg::Tag_t t;
        stdPkg::SqN_t s;
        stdPkg::StOff_t a;
        stdPkg::StOff_t b;
        openWindow();
        t = randTag();
        s = nextSqN();
        a = 2'($urandom);
        b = 2'($urandom);
        enq(op, t, 1'b1, s);
        expectNone(3);
        aguValid = 1'b1;
        aguOp = op;
        aguSqN = s;
        aguSrcA = a;
        aguSrcB = b;
        tick();
        aguValid = 1'b0;
        expectIssue(t, s, 2'((int'(a) + int'(b)) % 4));
    endtask

    task automatic testCbo();
        stdPkg::Opcode_t ops[3];
        stdPkg::SqN_t s[3];
        ops[0] = stdPkg::OP_CBO_CLEAN;
        ops[1] = stdPkg::OP_CBO_INVAL;
        ops[2] = stdPkg::OP_CBO_FLUSH;
        openWindow();
        for (int i = 0; i < 3; i++) begin
            s[i] = nextSqN();
            enq(ops[i], randTag(), 1'b0, s[i]);
        end
        for (int i = 0; i < 3; i++) expectIssue(stdPkg::TAG_ZERO + 7'(i), s[i], 2'd0);
    endtask

    task automatic testWindow();
        stdPkg::Tag_t t;
        stdPkg::SqN_t s;
        closeWindow();
        t = randTag();
        s = nextSqN();
        enq(stdPkg::OP_SW, t, 1'b1, s);
        expectNone(4);
        maxStoreSqN = s;
        expectIssue(t, s, 2'd0);
    endtask

    task automatic testBackPressure();
        stdPkg::Tag_t t[2];
        stdPkg::SqN_t s[2];
        openWindow();
        outReady = 1'b0;
        for (int i = 0; i < 2; i++) begin
            t[i] = randTag();
            s[i] = nextSqN();
            enq(stdPkg::OP_SW, t[i], 1'b1, s[i]);
        end
        waitOutValid();
        repeat (4) begin
            check("outValid held", outValid, 1);
            check("outTag held", outTag, t[0]);
            check("outSqN held", outSqN, s[0]);
            tick();
        end
        outReady = 1'b1;
        for (int i = 0; i < 2; i++) expectIssue(t[i], s[i], 2'd0);
    endtask

    task automatic testFull();
        stdPkg::Tag_t t[8];
        stdPkg::SqN_t s[8];
        closeWindow();
        for (int i = 0; i < 8; i++) begin
            t[i] = randTag();
            s[i] = nextSqN();
            enq(stdPkg::OP_SW, t[i], 1'b1, s[i]);
        end
        uopValid = 1'b1;
        uopOp = stdPkg::OP_SW;
        uopTag = randTag();
        uopSqN = nextSqN();
        #1;
        check("uopStall with full queue", uopStall, 1);
        // Non-store ops never stall
        uopOp = 4'd0;
        #1;
        check("uopStall for non-store op", uopStall, 0);
        tick();
        uopValid = 1'b0;
        openWindow();
        for (int i = 0; i < 8; i++) expectIssue(t[i], s[i], 2'd0);
        expectNone(3);
    endtask

    task automatic testRollback();
        stdPkg::Tag_t t[4];
        stdPkg::SqN_t s[4];
        closeWindow();
        for (int i = 0; i < 4; i++) begin
            t[i] = randTag();
            s[i] = nextSqN();
            enq(stdPkg::OP_SW, t[i], 1'b1, s[i]);
        end
        brTaken = 1'b1;
        brSqN = s[1];
        uopValid = 1'b1;
        uopOp = stdPkg::OP_SW;
        uopSqN = nextSqN();
        #1;
        check("uopStall in branch cycle", uopStall, 1);
        tick();
        brTaken = 1'b0;
        uopValid = 1'b0;
        check("comLimitSqN after rollback", comLimitSqN, s[0]);
        openWindow();
        expectIssue(t[0], s[0], 2'd0);
        expectIssue(t[1], s[1], 2'd0);
        expectNone(4);
        check("comLimitValid after rollback", comLimitValid, 0);
    endtask

    task automatic testFlush();
        stdPkg::SqN_t s;
        openWindow();
        outReady = 1'b0;
        for (int i = 0; i < 3; i++) begin
            s = nextSqN();
            enq(stdPkg::OP_SW, randTag(), 1'b1, s);
        end
        waitOutValid();
        brTaken = 1'b1;
        brFlush = 1'b1;
        brSqN = s;
        tick();
        brTaken = 1'b0;
        brFlush = 1'b0;
        check("outValid after flush", outValid, 0);
        check("comLimitValid after flush", comLimitValid, 0);
        outReady = 1'b1;
        expectNone(4);
    endtask

    initial begin
        void'($urandom(32'h82bf96dd));
        cycles = 0;
        rst = 1'b1;
        uopValid = 1'b0;
        uopOp = '0;
        uopTag = '0;
        uopAvail = 1'b0;
        uopSqN = '0;
        resValid = 1'b0;
        resTag = '0;
        aguValid = 1'b0;
        aguOp = '0;
        aguSqN = '0;
        aguSrcA = '0;
        aguSrcB = '0;
        brTaken = 1'b0;
        brFlush = 1'b0;
        brSqN = '0;
        maxStoreSqN = '0;
        outReady = 1'b1;
        sq = 6'($urandom);
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        testResetLimit();
        testInOrder();
        testWakeup();
        testSubWord(stdPkg::OP_SB);
        testSubWord(stdPkg::OP_SH);
        testCbo();
        testWindow();
        testBackPressure();
        testFull();
        testRollback();
        testFlush();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- vlog.f
stdPkg.sv
storeUopDecode.sv
storeDataQueue.sv
storeDataIssue.sv
storeDataTop.sv
tbStoreData.sv

//--- Bender.yml
package:
  name: storeData

sources:
  - files:
      - stdPkg.sv
      - storeUopDecode.sv
      - storeDataQueue.sv
      - storeDataIssue.sv
      - storeDataTop.sv
  - target: test
    files:
      - tbStoreData.sv
